//--- hdl/i2c_macros.svh
`ifndef I2C_MACROS_SVH
`define I2C_MACROS_SVH

// ############################################################
// Bus timing
// ############################################################

// clk_i cycles per quarter SCL period
`define I2C_DIV 4

// ############################################################
// Sizes
// ############################################################

`define I2C_QDEPTH 2    // Pending commands, power of two
`define I2C_MAXBYTES 4  // TDR and RDR are one 32-bit word

`endif

//--- hdl/i2c_pkg.sv
`default_nettype none
`include "i2c_macros.svh"

package i2c_pkg;

	// Register offsets on the host bus
	typedef enum logic [4:0] {
		REG_NBY  = 5'h00,
		REG_ADR  = 5'h04,
		REG_RDR  = 5'h08,
		REG_TDR  = 5'h0C,
		REG_CTRL = 5'h10
	} reg_addr_e;

	// One queued transfer
	typedef struct packed {
		logic [6:0]                       addr;
		logic                             read;
		logic [$clog2(`I2C_MAXBYTES)-1:0] nbytes;  // Count minus one
		logic [`I2C_MAXBYTES*8-1:0]       data;    // Byte 0 in bits 7:0
	} i2c_cmd_t;

	// Outcome of one finished transfer
	typedef struct packed {
		logic                       done;  // Single cycle
		logic                       nack;
		logic                       read;
		logic [`I2C_MAXBYTES*8-1:0] data;
	} i2c_result_t;

	// CTRL read view
	typedef struct packed {
		logic busy;
		logic done;
		logic nack;
		logic full;
	} i2c_status_t;

endpackage

`default_nettype wire

//--- hdl/i2c_regs.sv
`default_nettype none
`timescale 1ns/10ps
`include "i2c_macros.svh"

module i2c_regs (
	input  wire                         clk_i,
	input  wire                         rst_i,
	input  wire                         write_i,
	input  wire i2c_pkg::reg_addr_e     addr_i,
	input  wire [31:0]                  wdata_i,
	input  wire                         q_full_i,
	input  wire                         eng_active_i,
	input  wire                         q_empty_i,
	input  wire i2c_pkg::i2c_result_t   result_i,
	output logic [31:0]                 rdata_o,
	output logic                        push_o,
	output i2c_pkg::i2c_cmd_t           cmd_o
);

	logic [1:0]  nby_q;  // Count minus one
	logic [6:0]  adr_q;
	logic [31:0] tdr_q;
	logic [31:0] rdr_q;
	logic        done_q;
	logic        nack_q;
	logic        ctrl_wr;
	logic        start;
	logic        nby_ok;

	i2c_pkg::i2c_status_t status;

	assign ctrl_wr = write_i && (addr_i == i2c_pkg::REG_CTRL);
	assign start   = wdata_i[0] | wdata_i[1];  // Read wins if both set
	assign nby_ok  = (wdata_i != 32'd0) && (wdata_i <= 32'(`I2C_MAXBYTES));

	// ############################################################
	// Register writes and result capture
	// ############################################################

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			nby_q  <= 2'd0;
			adr_q  <= 7'd0;
			tdr_q  <= 32'd0;
			rdr_q  <= 32'd0;
			done_q <= 1'b0;
			nack_q <= 1'b0;
		end else begin
			if (write_i) begin
				case (addr_i)
					i2c_pkg::REG_NBY: begin
						if (nby_ok)
							nby_q <= wdata_i[1:0] - 2'd1;
						else
							nby_q <= 2'd0;  // Out of range counts as one byte
					end
					i2c_pkg::REG_ADR: adr_q <= wdata_i[6:0];
					i2c_pkg::REG_TDR: tdr_q <= wdata_i;
					default: ;
				endcase
			end

			if (ctrl_wr && wdata_i[2]) begin
				done_q <= 1'b0;
				nack_q <= 1'b0;
			end

			// Engine report overrides a clear in the same cycle
			if (result_i.done) begin
				done_q <= 1'b1;
				nack_q <= result_i.nack;
				if (result_i.read && !result_i.nack)
					rdr_q <= result_i.data;
			end
		end
	end

	// ############################################################
	// Command issue
	// ############################################################

	// Start while full is silently dropped
	assign push_o = ctrl_wr && start && !q_full_i;

	always_comb begin
		cmd_o.addr   = adr_q;
		cmd_o.read   = wdata_i[1];
		cmd_o.nbytes = nby_q;
		cmd_o.data   = tdr_q;
	end

	// ############################################################
	// Read mux
	// ############################################################

	always_comb begin
		status.busy = eng_active_i | ~q_empty_i;
		status.done = done_q;
		status.nack = nack_q;
		status.full = q_full_i;
	end

	always_comb begin
		case (addr_i)
			i2c_pkg::REG_NBY:  rdata_o = {30'd0, nby_q} + 32'd1;
			i2c_pkg::REG_ADR:  rdata_o = {25'd0, adr_q};
			i2c_pkg::REG_RDR:  rdata_o = rdr_q;
			i2c_pkg::REG_TDR:  rdata_o = tdr_q;
			i2c_pkg::REG_CTRL: rdata_o = {28'd0, status};
			default:           rdata_o = 32'd0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/i2c_cmd_queue.sv
`default_nettype none
`timescale 1ns/10ps
`include "i2c_macros.svh"

module i2c_cmd_queue (
	input  wire                      clk_i,
	input  wire                      rst_i,
	input  wire                      push_i,
	input  wire i2c_pkg::i2c_cmd_t   cmd_i,
	input  wire                      pop_i,
	output i2c_pkg::i2c_cmd_t        cmd_o,
	output logic                     empty_o,
	output logic                     full_o
);

	localparam int unsigned AW = $clog2(`I2C_QDEPTH);

	i2c_pkg::i2c_cmd_t mem [`I2C_QDEPTH];

	logic [AW:0] wr_ptr;  // Extra bit tells full from empty
	logic [AW:0] rd_ptr;
	logic        do_push;
	logic        do_pop;

	assign empty_o = (wr_ptr == rd_ptr);
	assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (do_push)
			mem[wr_ptr[AW-1:0]] <= cmd_i;
	end

	// Fall-through head
	assign cmd_o = mem[rd_ptr[AW-1:0]];

endmodule

`default_nettype wire

//--- hdl/i2c_bit_engine.sv
`default_nettype none
`timescale 1ns/10ps
`include "i2c_macros.svh"

module i2c_bit_engine (
	input  wire                      clk_i,
	input  wire                      rst_i,
	input  wire i2c_pkg::i2c_cmd_t   cmd_i,
	input  wire                      empty_i,
	input  wire                      sda_i,
	output logic                     pop_o,
	output logic                     active_o,
	output i2c_pkg::i2c_result_t     result_o,
	output logic                     scl_o,
	output logic                     sda_oe_o
);

	typedef enum logic [2:0] {
		IDLE, START, ADDR, ACK_ADDR, WDATA, RDATA, ACK_DATA, STOP
	} state_e;

	localparam int unsigned DIVW = $clog2(`I2C_DIV + 1);
	localparam int unsigned NBW  = $clog2(`I2C_MAXBYTES);
	localparam int unsigned DW   = `I2C_MAXBYTES * 8;

	state_e          state_q;
	logic [DIVW-1:0] div_cnt;
	logic [1:0]      qtr;       // Quarter of the current bit
	logic            tick;
	logic            sample;
	logic            bit_end;
	logic            scl_hi;
	logic [2:0]      bit_cnt;
	logic [NBW-1:0]  byte_cnt;
	logic [NBW-1:0]  byte_nxt;
	logic [NBW-1:0]  last_q;
	logic            last_byte;
	logic            rd_q;
	logic            nack_q;
	logic            ack_q;     // Sampled ACK slot, high means NACK
	logic [7:0]      shift_q;
	logic [DW-1:0]   tx_q;
	logic [DW-1:0]   rx_q;

	assign tick      = (div_cnt == DIVW'(`I2C_DIV - 1));
	assign sample    = tick && (qtr == 2'd2);
	assign bit_end   = tick && (qtr == 2'd3);
	assign scl_hi    = (qtr == 2'd1) || (qtr == 2'd2);
	assign byte_nxt  = byte_cnt + 1'b1;
	assign last_byte = (byte_cnt == last_q);

	assign pop_o    = (state_q == IDLE) && !empty_i;
	assign active_o = (state_q != IDLE);

	// ############################################################
	// Quarter tick divider
	// ############################################################

	always_ff @(posedge clk_i) begin
		if (rst_i || state_q == IDLE) begin
			div_cnt <= '0;
			qtr     <= 2'd0;
		end else if (tick) begin
			div_cnt <= '0;
			qtr     <= qtr + 2'd1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// ############################################################
	// Control FSM, advances once per bit
	// ############################################################

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q  <= IDLE;
			nack_q   <= 1'b0;
			bit_cnt  <= 3'd0;
			byte_cnt <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (!empty_i) begin
						state_q  <= START;
						nack_q   <= 1'b0;
						bit_cnt  <= 3'd7;
						byte_cnt <= '0;
					end
				end
				START: if (bit_end) state_q <= ADDR;
				ADDR, WDATA, RDATA: begin
					if (bit_end) begin
						if (bit_cnt == 3'd0)
							state_q <= (state_q == ADDR) ? ACK_ADDR : ACK_DATA;
						else
							bit_cnt <= bit_cnt - 3'd1;
					end
				end
				ACK_ADDR: begin
					if (bit_end) begin
						bit_cnt <= 3'd7;
						if (ack_q) begin
							nack_q  <= 1'b1;  // No slave at this address
							state_q <= STOP;
						end else begin
							state_q <= rd_q ? RDATA : WDATA;
						end
					end
				end
				ACK_DATA: begin
					if (bit_end) begin
						bit_cnt <= 3'd7;
						if (!rd_q && ack_q) begin
							nack_q  <= 1'b1;
							state_q <= STOP;
						end else if (last_byte) begin
							state_q <= STOP;
						end else begin
							byte_cnt <= byte_nxt;
							state_q  <= rd_q ? RDATA : WDATA;
						end
					end
				end
				STOP: if (bit_end) state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clk_i) begin
		if (pop_o) begin
			shift_q <= {cmd_i.addr, cmd_i.read};
			tx_q    <= cmd_i.data;
			rd_q    <= cmd_i.read;
			last_q  <= cmd_i.nbytes;
			rx_q    <= '0;  // Unused bytes read as zero
		end
		if (bit_end && (state_q == ADDR || state_q == WDATA))
			shift_q <= {shift_q[6:0], 1'b0};  // MSB first
		if (bit_end && state_q == ACK_ADDR)
			shift_q <= tx_q[7:0];
		if (bit_end && state_q == ACK_DATA)
			shift_q <= tx_q[{byte_nxt, 3'b000} +: 8];
		if (sample && (state_q == ACK_ADDR || state_q == ACK_DATA))
			ack_q <= sda_i;
		if (sample && state_q == RDATA)
			rx_q[{byte_cnt, bit_cnt}] <= sda_i;
	end

	// ############################################################
	// Pins and result
	// ############################################################

	always_comb begin
		scl_o    = 1'b1;
		sda_oe_o = 1'b0;
		case (state_q)
			START: begin
				scl_o    = (qtr != 2'd3);
				sda_oe_o = (qtr != 2'd0);  // SDA falls with SCL high
			end
			ADDR, WDATA: begin
				scl_o    = scl_hi;
				sda_oe_o = ~shift_q[7];
			end
			ACK_ADDR, RDATA: scl_o = scl_hi;
			ACK_DATA: begin
				scl_o    = scl_hi;
				sda_oe_o = rd_q && !last_byte;  // Master NACKs the last byte
			end
			STOP: begin
				scl_o    = (qtr != 2'd0);
				sda_oe_o = (qtr < 2'd2);  // SDA rises with SCL high
			end
			default: ;
		endcase
	end

	always_comb begin
		result_o.done = (state_q == STOP) && bit_end;
		result_o.nack = nack_q;
		result_o.read = rd_q;
		result_o.data = rx_q;
	end

endmodule

`default_nettype wire

//--- hdl/i2c_master.sv
`default_nettype none
`timescale 1ns/10ps

module i2c_master (
	input  wire        clk_i,
	input  wire        rst_i,
	input  wire        write_i,
	input  wire [4:0]  addr_i,
	input  wire [31:0] wdata_i,
	output wire [31:0] rdata_o,
	input  wire        sda_i,
	output wire        scl_o,
	output wire        sda_oe_o
);

	wire i2c_pkg::reg_addr_e   reg_addr;
	wire i2c_pkg::i2c_cmd_t    push_cmd;
	wire i2c_pkg::i2c_cmd_t    head_cmd;
	wire i2c_pkg::i2c_result_t result;
	wire                       push;
	wire                       pop;
	wire                       q_full;
	wire                       q_empty;
	wire                       eng_active;

	assign reg_addr = i2c_pkg::reg_addr_e'(addr_i);

	i2c_regs u_regs (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.write_i      (write_i),
		.addr_i       (reg_addr),
		.wdata_i      (wdata_i),
		.q_full_i     (q_full),
		.eng_active_i (eng_active),
		.q_empty_i    (q_empty),
		.result_i     (result),
		.rdata_o      (rdata_o),
		.push_o       (push),
		.cmd_o        (push_cmd)
	);

	i2c_cmd_queue u_queue (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.push_i  (push),
		.cmd_i   (push_cmd),
		.pop_i   (pop),
		.cmd_o   (head_cmd),
		.empty_o (q_empty),
		.full_o  (q_full)
	);

	i2c_bit_engine u_engine (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.cmd_i    (head_cmd),
		.empty_i  (q_empty),
		.sda_i    (sda_i),
		.pop_o    (pop),
		.active_o (eng_active),
		.result_o (result),
		.scl_o    (scl_o),
		.sda_oe_o (sda_oe_o)
	);

endmodule

`default_nettype wire

//--- bench/i2c_slave_model.sv
`default_nettype none
`timescale 1ns/10ps

module i2c_slave_model #(
	parameter logic [6:0] DEV_ADDR = 7'h2A
) (
	input  wire  scl_i,
	input  wire  sda_i,
	output logic sda_pull_o  // High pulls SDA low
);

	logic [7:0] mem [4];
	logic [7:0] shift;
	logic [1:0] byte_idx;
	logic       scl_prev;
	logic       sda_prev;
	logic       active;
	logic       first;       // Address byte in progress
	logic       selected;
	logic       reading;
	logic       master_ack;
	int         bit_idx;     // 8 is the ACK slot

	task automatic start_seen();
		active     = 1'b1;
		first      = 1'b1;
		selected   = 1'b0;
		reading    = 1'b0;
		bit_idx    = -1;  // SCL still has to fall once
		byte_idx   = 2'd0;
		sda_pull_o = 1'b0;
	endtask

	task automatic sample_bit();
		if (active) begin
			if (bit_idx >= 0 && bit_idx < 8 && !reading)
				shift = {shift[6:0], sda_i};
			else if (bit_idx == 8 && reading)
				master_ack = !sda_i;
		end
	endtask

	task automatic enter_ack_slot();
		if (first) begin
			selected   = (shift[7:1] == DEV_ADDR);
			sda_pull_o = selected;  // Only our own address is acknowledged
		end else if (reading) begin
			sda_pull_o = 1'b0;      // Master owns this slot
		end else begin
			mem[byte_idx] = shift;
			byte_idx      = byte_idx + 2'd1;
			sda_pull_o    = 1'b1;
		end
	endtask

	task automatic leave_ack_slot();
		sda_pull_o = 1'b0;
		if (first) begin
			first   = 1'b0;
			reading = shift[0];
			active  = selected;
			if (selected && reading) begin
				shift      = mem[byte_idx];
				sda_pull_o = !shift[7];
			end
		end else if (reading) begin
			if (master_ack) begin
				byte_idx   = byte_idx + 2'd1;
				shift      = mem[byte_idx];
				sda_pull_o = !shift[7];
			end else begin
				active = 1'b0;  // Last byte, STOP follows
			end
		end
	endtask

	task automatic advance_bit();
		if (active) begin
			if (bit_idx == 7) begin
				bit_idx = 8;
				enter_ack_slot();
			end else if (bit_idx == 8) begin
				bit_idx = 0;
				leave_ack_slot();
			end else begin
				bit_idx = bit_idx + 1;
				if (reading) begin
					shift      = {shift[6:0], 1'b0};
					sda_pull_o = !shift[7];
				end
			end
		end
	endtask

	// ############################################################
	// Edge watcher
	// ############################################################

	initial begin
		sda_pull_o = 1'b0;
		active     = 1'b0;
		master_ack = 1'b0;
		foreach (mem[i])
			mem[i] = 8'h00;
		scl_prev = scl_i;
		sda_prev = sda_i;
		forever begin
			@(scl_i or sda_i);
			if (scl_i && !scl_prev)
				sample_bit();
			else if (!scl_i && scl_prev)
				advance_bit();
			else if (scl_i && (sda_i != sda_prev)) begin
				if (!sda_i)
					start_seen();
				else
					active = 1'b0;  // STOP
			end
			scl_prev = scl_i;
			sda_prev = sda_i;
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_i2c_master.sv
`default_nettype none
`timescale 1ns/10ps
`include "i2c_macros.svh"

module tb_i2c_master;

	localparam int CLK_PERIOD  = 8;
	localparam int BIT_CYCLES  = 4 * `I2C_DIV;
	localparam int NUM_XFERS   = 8;
	localparam int WATCHDOG_NS = NUM_XFERS * 46 * BIT_CYCLES * CLK_PERIOD + 20000;
	localparam int POLL_LIMIT  = 3 * 47 * BIT_CYCLES;  // Two queued transfers plus slack

	localparam logic [4:0] A_NBY  = 5'h00;
	localparam logic [4:0] A_ADR  = 5'h04;
	localparam logic [4:0] A_RDR  = 5'h08;
	localparam logic [4:0] A_TDR  = 5'h0C;
	localparam logic [4:0] A_CTRL = 5'h10;

	localparam int ST_BUSY = 3;  // CTRL read bits 3:0 are busy, done, nack, full

	logic        clk = 1'b0;
	logic        rst;
	logic        write;
	logic [4:0]  addr;
	logic [31:0] wdata;
	logic [31:0] rng_state;
	wire  [31:0] rdata;
	wire         scl;
	wire         sda_oe;
	wire         slave_pull;
	wire         sda_line;

	assign sda_line = !(sda_oe || slave_pull);  // Pull-up, open-drain pull-downs

	always #(CLK_PERIOD / 2) clk = !clk;

	i2c_master i_dut (
		.clk_i    (clk),
		.rst_i    (rst),
		.write_i  (write),
		.addr_i   (addr),
		.wdata_i  (wdata),
		.rdata_o  (rdata),
		.sda_i    (sda_line),
		.scl_o    (scl),
		.sda_oe_o (sda_oe)
	);

	i2c_slave_model #(.DEV_ADDR(7'h2A)) u_slave (
		.scl_i      (scl),
		.sda_i      (sda_line),
		.sda_pull_o (slave_pull)
	);

	// ############################################################
	// Helpers, called and returning on a falling edge
	// ############################################################

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic reg_write(input logic [4:0] a, input logic [31:0] d);
		write = 1'b1;
		addr  = a;
		wdata = d;
		@(negedge clk);
		write = 1'b0;
	endtask

	task automatic reg_read(input logic [4:0] a, output logic [31:0] d);
		write = 1'b0;
		addr  = a;
		#(CLK_PERIOD / 4);
		d = rdata;
		@(negedge clk);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic wait_idle(input string name);
		logic [31:0] st;
		int          polls;
		polls = 0;
		reg_read(A_CTRL, st);
		while (st[ST_BUSY] && polls < POLL_LIMIT) begin
			reg_read(A_CTRL, st);
			polls++;
		end
		if (st[ST_BUSY]) begin
			$display("%s: bus still busy after %0d status polls", name, POLL_LIMIT);
			$display("TEST RESULT: FAIL");
			$fatal(1, "transfer never finished");
		end
	endtask

	// Clear flags and start in one write, then check the final status
	task automatic run_transfer(input string name, input logic [31:0] start_bits,
			input logic [31:0] exp_status);
		logic [31:0] st;
		reg_write(A_CTRL, 32'h4 | start_bits);
		wait_idle(name);
		reg_read(A_CTRL, st);
		check_value(name, exp_status, st);
	endtask

	// Bus must rest while nothing is queued or running
	always @(negedge clk) begin
		if (!rst && !(i_dut.eng_active || !i_dut.q_empty)) begin
			assert (scl && !sda_oe) else begin
				$display("CHECK FAILED idle_bus: expected 0x2, actual 0x%0h", {scl, sda_oe});
				$display("TEST RESULT: FAIL");
				$fatal(1, "bus driven while idle");
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Simulation timed out after %0d ns", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	// ############################################################
	// Stimulus
	// ############################################################

	initial begin
		logic [31:0] val;
		logic [31:0] word_a;
		logic [31:0] word_b;
		rst       = 1'b1;
		write     = 1'b0;
		addr      = 5'h00;
		wdata     = 32'h0;
		rng_state = 32'h84af;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Reset values and register round trip
		reg_read(A_CTRL, val);
		check_value("reset_ctrl", 32'h0, val);
		reg_read(A_NBY, val);
		check_value("reset_nby", 32'd1, val);
		reg_write(A_ADR, 32'hffff_ffaa);
		reg_read(A_ADR, val);
		check_value("adr_mask", 32'h0000_002a, val);
		word_a = next_random();
		reg_write(A_TDR, word_a);
		reg_read(A_TDR, val);
		check_value("tdr_rw", word_a, val);
		reg_write(A_NBY, 32'd3);
		reg_read(A_NBY, val);
		check_value("nby_three", 32'd3, val);
		reg_write(A_NBY, 32'd0);
		reg_read(A_NBY, val);
		check_value("nby_zero", 32'd1, val);
		reg_write(A_NBY, 32'd3);
		reg_write(A_NBY, 32'd7);
		reg_read(A_NBY, val);
		check_value("nby_over", 32'd1, val);
		reg_write(A_NBY, 32'd4);

		// Four bytes out and back
		run_transfer("write4", 32'h1, 32'h4);
		run_transfer("read4", 32'h2, 32'h4);
		reg_read(A_RDR, val);
		check_value("rdr_full", word_a, val);

		// Two byte transfers leave the upper bytes zero
		word_b = next_random();
		reg_write(A_NBY, 32'd2);
		reg_write(A_TDR, word_b);
		run_transfer("write2", 32'h1, 32'h4);
		run_transfer("read2", 32'h2, 32'h4);
		reg_read(A_RDR, val);
		check_value("rdr_partial", {16'h0, word_b[15:0]}, val);

		// No slave at 7'h11
		reg_write(A_ADR, 32'h11);
		run_transfer("addr_nack", 32'h2, 32'h6);
		reg_read(A_RDR, val);
		check_value("rdr_kept", {16'h0, word_b[15:0]}, val);
		reg_write(A_CTRL, 32'h4);
		reg_read(A_CTRL, val);
		check_value("flag_clear", 32'h0, val);
		reg_write(A_ADR, 32'h2a);

		// Queue two more behind a running write
		word_a = next_random();
		word_b = next_random();
		reg_write(A_NBY, 32'd4);
		reg_write(A_TDR, word_a);
		reg_write(A_CTRL, 32'h5);
		reg_write(A_TDR, word_b);
		reg_write(A_CTRL, 32'h1);
		reg_write(A_CTRL, 32'h2);
		reg_read(A_CTRL, val);
		check_value("queue_full", 32'h9, val);
		wait_idle("queue_drain");
		reg_read(A_CTRL, val);
		check_value("queue_status", 32'h4, val);
		reg_read(A_RDR, val);
		check_value("queue_order", word_b, val);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- i2c_master.f
+incdir+hdl
hdl/i2c_pkg.sv
hdl/i2c_regs.sv
hdl/i2c_cmd_queue.sv
hdl/i2c_bit_engine.sv
hdl/i2c_master.sv
bench/i2c_slave_model.sv
bench/tb_i2c_master.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := tb_i2c_master
FILELIST  := i2c_master.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only if the pass line shows up in the simulator output
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
